//--- bench/nqv_testdata.txt
// Words 0..2: program length, store count, preloaded data words
// 'h10: program words, 'h40: data memory from word 0, 'h50: store pairs (address, value)
0000001F 0000000E 00000004
@10
12300093 10102023 FFF08113 0F017193 5051E213 FFF24293 10202223 10302423
10402623 10502823 00508333 10602A23 404083B3 10702C23 00437433 10802E23
0013E4B3 12902023 0064C533 12A02223 ABCDE5B7 12B02423 00508013 12002623
00802603 00C02683 00D60733 12E02823 10002783 40C787B3 12F02A23
@40
DEADBEEF 01234567 13572468 89ABCDEF
@50
00000100 00000123
00000104 00000122
00000108 00000020
0000010C 00000525
00000110 FFFFFADA
00000114 FFFFFBFD
00000118 FFFFFBFE
0000011C 00000125
00000120 FFFFFBFF
00000124 00000002
00000128 ABCDE000
0000012C 00000000
00000130 9D02F257
00000134 ECA8DCBB

//--- nqv.f
src/nqv_pkg.sv
src/nqv_fetch.sv
src/nqv_decoder.sv
src/nqv_core.sv
src/nqv_cpu.sv
src/nqv_top.sv
bench/nqv_tb.sv

//--- Bender.yml
package:
  name: nqv

sources:
  - src/nqv_pkg.sv
  - src/nqv_fetch.sv
  - src/nqv_decoder.sv
  - src/nqv_core.sv
  - src/nqv_cpu.sv
  - src/nqv_top.sv
  - target: test
    files:
      - bench/nqv_tb.sv

//--- bench/nqv_tb.sv
`timescale 1ns/1ps
// nqv testbench
// Runs a small RV32E program from the testdata file and checks every store on the data bus
module nqv_tb;
    import nqv_pkg::*;

    logic                       clk = 1'b0;
    logic                       rstn;
    logic [INSTR_ADDR_BITS-1:0] instr_addr;
    logic                       instr_fetch_restart;
    logic                       instr_fetch_stall;
    logic [15:0]                instr_data_in;
    logic                       instr_ready;
    logic [DATA_ADDR_BITS-1:0]  data_addr;
    logic [1:0]                 data_write_n;
    logic [1:0]                 data_read_n;
    logic [31:0]                data_out;
    logic [31:0]                data_in;
    logic                       data_ready;
    logic                       instr_complete;

    logic [31:0] td [0:127];  // Counts at 0, program at 'h10, data at 'h40, stores at 'h50
    logic [31:0] dmem [0:255];
    logic [31:0] rng;
    int          nprog;
    int          nstores;
    int          fetch_idx;
    int          store_count;
    int          complete_count;
    int          cycles;
    int          limit;
    int          delay;
    bit          busy;

    nqv_top #(.NUM_REGS(16)) dut (.*);

    always #2 clk = !clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // Both memory models run on the falling edge, where DUT outputs are settled
    always @(negedge clk) begin
        // With one instruction in flight the buffer holds this many halfwords or two fewer
        if (fetch_idx - 2 * complete_count >= 6) begin
            check_value("fetch stall", 32'd1, 32'(instr_fetch_stall));
        end else if (fetch_idx - 2 * complete_count < 4) begin
            check_value("fetch stall", 32'd0, 32'(instr_fetch_stall));
        end
        if (instr_complete) complete_count++;
        rng = xorshift32(rng);
        if (instr_fetch_restart) begin
            fetch_idx   = int'(instr_addr);
            instr_ready = 1'b0;
        end else if (!instr_fetch_stall && fetch_idx < 2 * nprog && rng[1:0] != 2'b00) begin
            check_value("fetch address", 32'(fetch_idx), 32'(instr_addr));
            instr_data_in = fetch_idx[0] ? td['h10 + fetch_idx / 2][31:16]
                                         : td['h10 + fetch_idx / 2][15:0];
            instr_ready   = 1'b1;
            fetch_idx++;
        end else begin
            instr_ready = 1'b0;
        end

        if (!rstn || data_ready) begin
            data_ready = 1'b0;  // The strobe has already dropped
        end else if (busy) begin
            if (delay == 0) begin
                data_in    = dmem[data_addr[9:2]];
                data_ready = 1'b1;
                busy       = 1'b0;
            end else begin
                delay--;
            end
        end else if (data_write_n != MEM_NONE || data_read_n != MEM_NONE) begin
            if (data_write_n != MEM_NONE) begin
                if (store_count >= nstores) stop_with_error("store beyond the expected list");
                check_value("store address", td['h50 + 2 * store_count], 32'(data_addr));
                check_value("store data", td['h51 + 2 * store_count], data_out);
                dmem[data_addr[9:2]] = data_out;
                store_count++;
            end
            busy  = 1'b1;
            delay = int'(rng[10:8] % 3'd6);  // Answer 1 to 6 cycles later
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) stop_with_error("timeout, the program did not finish in time");
    end

    initial begin
        rstn           = 1'b0;
        instr_data_in  = '0;
        instr_ready    = 1'b0;
        data_in        = '0;
        data_ready     = 1'b0;
        rng            = 32'h7252e33f;
        fetch_idx      = 0;
        store_count    = 0;
        complete_count = 0;
        cycles         = 0;
        busy           = 1'b0;
        delay          = 0;
        $readmemh("bench/nqv_testdata.txt", td);
        nprog   = int'(td[0]);
        nstores = int'(td[1]);
        limit   = nprog * NIBBLES * 16;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hc0de0000 ^ (i * 32'h00010004);
        end
        for (int i = 0; i < int'(td[2]); i++) begin
            dmem[i] = td['h40 + i];
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        #1;
        check_value("reset write strobe", 32'(MEM_NONE), 32'(data_write_n));
        check_value("reset read strobe", 32'(MEM_NONE), 32'(data_read_n));
        check_value("reset restart", 32'd1, 32'(instr_fetch_restart));
        check_value("reset fetch address", 32'd0, 32'(instr_addr));
        check_value("reset complete", 32'd0, 32'(instr_complete));

        wait (store_count == nstores);
        wait (data_write_n == MEM_NONE && data_read_n == MEM_NONE);
        repeat (2 * NIBBLES) @(negedge clk);
        check_value("completions", 32'(nprog), 32'(complete_count));
        check_value("final write strobe", 32'(MEM_NONE), 32'(data_write_n));
        check_value("final read strobe", 32'(MEM_NONE), 32'(data_read_n));
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- src/nqv_top.sv
`timescale 1ns/1ps
// nqv top level
// Fetch buffer, decoder, sequencer and nibble-serial core
module nqv_top #(
    parameter int NUM_REGS = 16
) (
    input  logic                                 clk,
    input  logic                                 rstn,
    output logic [nqv_pkg::INSTR_ADDR_BITS-1:0] instr_addr,
    output logic                                 instr_fetch_restart,
    output logic                                 instr_fetch_stall,
    input  logic [15:0]                          instr_data_in,
    input  logic                                 instr_ready,
    output logic [nqv_pkg::DATA_ADDR_BITS-1:0]  data_addr,
    output logic [1:0]                           data_write_n,
    output logic [1:0]                           data_read_n,
    output logic [31:0]                          data_out,
    input  logic [31:0]                          data_in,
    input  logic                                 data_ready,
    output logic                                 instr_complete
);
    import nqv_pkg::*;

    logic [31:0]               instr;
    logic                      instr_avail;
    logic                      instr_taken;
    logic                      is_load_de;
    logic                      is_store_de;
    logic                      is_alu_imm_de;
    logic                      is_alu_reg_de;
    logic                      is_lui_de;
    alu_op_t                   alu_op_de;
    logic [3:0]                rs1_de;
    logic [3:0]                rs2_de;
    logic [3:0]                rd_de;
    logic [31:0]               imm_de;
    logic                      is_load;
    logic                      is_store;
    logic                      is_alu_imm;
    logic                      is_alu_reg;
    logic                      is_lui;
    logic                      is_stall;
    alu_op_t                   alu_op;
    logic [3:0]                rs1;
    logic [3:0]                rs2;
    logic [3:0]                rd;
    logic [3:0]                imm_nibble;
    logic [$clog2(NIBBLES)-1:0] counter;
    logic                      load_data_ready;
    logic [31:0]               load_data;
    logic [3:0]                data_out_nibble;
    logic [DATA_ADDR_BITS-1:0] addr_out;
    logic                      address_ready;
    logic                      instr_complete_core;

    nqv_fetch i_fetch (
        .clk(clk), .rstn(rstn),
        .instr_data_in(instr_data_in), .instr_ready(instr_ready), .instr_taken(instr_taken),
        .instr_addr(instr_addr), .instr_fetch_restart(instr_fetch_restart),
        .instr_fetch_stall(instr_fetch_stall),
        .instr(instr), .instr_avail(instr_avail)
    );

    nqv_decoder i_decoder (
        .instr(instr),
        .is_load(is_load_de), .is_store(is_store_de), .is_alu_imm(is_alu_imm_de),
        .is_alu_reg(is_alu_reg_de), .is_lui(is_lui_de), .alu_op(alu_op_de),
        .rs1(rs1_de), .rs2(rs2_de), .rd(rd_de), .imm(imm_de)
    );

    nqv_cpu i_cpu (
        .clk(clk), .rstn(rstn),
        .is_load_de(is_load_de), .is_store_de(is_store_de), .is_alu_imm_de(is_alu_imm_de),
        .is_alu_reg_de(is_alu_reg_de), .is_lui_de(is_lui_de), .alu_op_de(alu_op_de),
        .rs1_de(rs1_de), .rs2_de(rs2_de), .rd_de(rd_de), .imm_de(imm_de),
        .instr_avail(instr_avail), .instr_taken(instr_taken),
        .is_load(is_load), .is_store(is_store), .is_alu_imm(is_alu_imm),
        .is_alu_reg(is_alu_reg), .is_lui(is_lui), .is_stall(is_stall), .alu_op(alu_op),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm_nibble(imm_nibble), .counter(counter),
        .load_data_ready(load_data_ready), .load_data(load_data),
        .data_out_nibble(data_out_nibble), .addr_out(addr_out),
        .address_ready(address_ready), .instr_complete_core(instr_complete_core),
        .data_addr(data_addr), .data_write_n(data_write_n), .data_read_n(data_read_n),
        .data_out(data_out), .data_in(data_in), .data_ready(data_ready),
        .instr_complete(instr_complete)
    );

    nqv_core #(.NUM_REGS(NUM_REGS)) i_core (
        .clk(clk), .rstn(rstn),
        .is_load(is_load), .is_store(is_store), .is_alu_imm(is_alu_imm),
        .is_alu_reg(is_alu_reg), .is_lui(is_lui), .is_stall(is_stall), .alu_op(alu_op),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm_nibble(imm_nibble), .counter(counter),
        .load_data_ready(load_data_ready), .data_in(load_data),
        .data_out_nibble(data_out_nibble), .addr_out(addr_out),
        .address_ready(address_ready), .instr_complete_core(instr_complete_core)
    );

endmodule

//--- src/nqv_cpu.sv
`timescale 1ns/1ps
// nqv sequencer
// Registers decoded instructions, runs the nibble counter and drives the data bus
module nqv_cpu (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                is_load_de,
    input  logic                                is_store_de,
    input  logic                                is_alu_imm_de,
    input  logic                                is_alu_reg_de,
    input  logic                                is_lui_de,
    input  nqv_pkg::alu_op_t                    alu_op_de,
    input  logic [3:0]                          rs1_de,
    input  logic [3:0]                          rs2_de,
    input  logic [3:0]                          rd_de,
    input  logic [31:0]                         imm_de,
    input  logic                                instr_avail,
    output logic                                instr_taken,
    output logic                                is_load,
    output logic                                is_store,
    output logic                                is_alu_imm,
    output logic                                is_alu_reg,
    output logic                                is_lui,
    output logic                                is_stall,
    output nqv_pkg::alu_op_t                    alu_op,
    output logic [3:0]                          rs1,
    output logic [3:0]                          rs2,
    output logic [3:0]                          rd,
    output logic [3:0]                          imm_nibble,
    output logic [$clog2(nqv_pkg::NIBBLES)-1:0] counter,
    output logic                                load_data_ready,
    output logic [31:0]                         load_data,
    input  logic [3:0]                          data_out_nibble,
    input  logic [nqv_pkg::DATA_ADDR_BITS-1:0]  addr_out,
    input  logic                                address_ready,
    input  logic                                instr_complete_core,
    output logic [nqv_pkg::DATA_ADDR_BITS-1:0]  data_addr,
    output nqv_pkg::mem_size_t                  data_write_n,
    output nqv_pkg::mem_size_t                  data_read_n,
    output logic [31:0]                         data_out,
    input  logic [31:0]                         data_in,
    input  logic                                data_ready,
    output logic                                instr_complete
);
    import nqv_pkg::*;

    localparam int CNT_BITS = $clog2(NIBBLES);
    localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(NIBBLES - 1);

    logic        is_load_r;
    logic        is_store_r;
    logic        is_alu_imm_r;
    logic        is_alu_reg_r;
    logic        is_lui_r;
    logic [31:0] imm_r;
    logic        instr_valid;
    logic        no_write_in_progress;
    logic        load_started;
    logic        ready_latch;
    logic        read_ready;
    logic        take_slot;
    logic        last;

    assign last        = counter == CNT_LAST;
    assign take_slot   = last && (instr_complete_core || !instr_valid);
    assign instr_taken = take_slot && instr_avail;
    assign read_ready  = data_ready && data_read_n != MEM_NONE;

    assign instr_complete = instr_complete_core;

    // A memory op waits for the previous write, a load also waits for its data
    assign is_stall = !instr_valid ||
                      ((is_load_r || is_store_r) && !no_write_in_progress) ||
                      (is_load_r && load_started && !load_data_ready);

    assign is_load    = is_load_r && instr_valid && no_write_in_progress;
    assign is_store   = is_store_r && instr_valid && no_write_in_progress;
    assign is_alu_imm = is_alu_imm_r && instr_valid;
    assign is_alu_reg = is_alu_reg_r && instr_valid;
    assign is_lui     = is_lui_r && instr_valid;
    assign imm_nibble = imm_r[{counter, 2'b00} +: 4];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            counter      <= '0;
            instr_valid  <= 1'b0;
            is_load_r    <= 1'b0;
            is_store_r   <= 1'b0;
            is_alu_imm_r <= 1'b0;
            is_alu_reg_r <= 1'b0;
            is_lui_r     <= 1'b0;
        end else begin
            counter <= counter + 1'b1;
            if (take_slot) begin
                instr_valid  <= instr_avail;
                is_load_r    <= is_load_de;
                is_store_r   <= is_store_de;
                is_alu_imm_r <= is_alu_imm_de;
                is_alu_reg_r <= is_alu_reg_de;
                is_lui_r     <= is_lui_de;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_slot) begin
            alu_op <= alu_op_de;
            rs1    <= rs1_de;
            rs2    <= rs2_de;
            rd     <= rd_de;
            imm_r  <= imm_de;
        end
    end

    // Read data seen during a round is presented from the next counter zero
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ready_latch     <= 1'b0;
            load_data_ready <= 1'b0;
        end else if (last) begin
            load_data_ready <= ready_latch || read_ready;
            ready_latch     <= 1'b0;
        end else if (read_ready) begin
            ready_latch <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (read_ready) begin
            load_data <= data_in;
        end
        if (address_ready) begin
            data_addr <= addr_out;
        end
        if (is_store) begin
            data_out[{counter, 2'b00} +: 4] <= data_out_nibble;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            data_write_n         <= MEM_NONE;
            no_write_in_progress <= 1'b1;
        end else if (address_ready && is_store) begin
            data_write_n         <= MEM_WORD;
            no_write_in_progress <= 1'b0;
        end else begin
            if (data_ready) begin
                data_write_n <= MEM_NONE;
            end
            if (last) begin  // Only changes between rounds
                no_write_in_progress <= data_write_n == MEM_NONE || data_ready;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            data_read_n  <= MEM_NONE;
            load_started <= 1'b0;
        end else if (address_ready && is_load) begin
            data_read_n  <= MEM_WORD;
            load_started <= 1'b1;
        end else begin
            if (data_ready) begin
                data_read_n <= MEM_NONE;
            end
            if (instr_complete_core) begin
                load_started <= 1'b0;
            end
        end
    end

endmodule

//--- src/nqv_core.sv
`timescale 1ns/1ps
// nqv serial core
// Register file, ALU and address generation, one nibble per clock
module nqv_core #(
    parameter int NUM_REGS = 16
) (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  is_load,
    input  logic                                  is_store,
    input  logic                                  is_alu_imm,
    input  logic                                  is_alu_reg,
    input  logic                                  is_lui,
    input  logic                                  is_stall,
    input  nqv_pkg::alu_op_t                      alu_op,
    input  logic [3:0]                            rs1,
    input  logic [3:0]                            rs2,
    input  logic [3:0]                            rd,
    input  logic [3:0]                            imm_nibble,
    input  logic [$clog2(nqv_pkg::NIBBLES)-1:0]   counter,
    input  logic                                  load_data_ready,
    input  logic [31:0]                           data_in,
    output logic [3:0]                            data_out_nibble,
    output logic [nqv_pkg::DATA_ADDR_BITS-1:0]    addr_out,
    output logic                                  address_ready,
    output logic                                  instr_complete_core
);
    import nqv_pkg::*;

    localparam int REG_ADDR_BITS = $clog2(NUM_REGS);
    localparam int CNT_BITS      = $clog2(NIBBLES);
    localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(NIBBLES - 1);

    logic [31:0]               regs [1:NUM_REGS-1];  // Nibble for this cycle sits in [3:0]
    logic [REG_ADDR_BITS-1:0]  rs1_a;
    logic [REG_ADDR_BITS-1:0]  rs2_a;
    logic [REG_ADDR_BITS-1:0]  rd_a;
    logic [3:0]                rs1_nib;
    logic [3:0]                rs2_nib;
    logic [3:0]                op_b;
    logic [3:0]                result;
    logic [3:0]                rd_nib;
    logic [4:0]                sum;
    logic                      is_sub;
    logic                      carry;
    logic                      carry_in;
    logic                      reg_wen;
    logic                      last;
    logic                      load_wait;
    logic [DATA_ADDR_BITS-1:0] addr_sr;

    assign rs1_a = rs1[REG_ADDR_BITS-1:0];
    assign rs2_a = rs2[REG_ADDR_BITS-1:0];
    assign rd_a  = rd[REG_ADDR_BITS-1:0];

    assign rs1_nib = (rs1_a == '0) ? 4'h0 : regs[rs1_a][3:0];  // x0 reads zero
    assign rs2_nib = (rs2_a == '0) ? 4'h0 : regs[rs2_a][3:0];

    assign last      = counter == CNT_LAST;
    assign load_wait = is_load && !load_data_ready;  // Address round of a load

    // Subtraction adds the inverted operand with a carry-in of one
    assign is_sub   = alu_op == ALU_SUB;
    assign op_b     = is_alu_reg ? rs2_nib : imm_nibble;
    assign carry_in = (counter == '0) ? is_sub : carry;
    assign sum      = {1'b0, rs1_nib} + {1'b0, op_b ^ {4{is_sub}}} + {4'b0000, carry_in};

    always_comb begin
        case (alu_op)
            ALU_AND:      result = rs1_nib & op_b;
            ALU_OR:       result = rs1_nib | op_b;
            ALU_XOR:      result = rs1_nib ^ op_b;
            ALU_PASS_IMM: result = imm_nibble;
            default:      result = sum[3:0];
        endcase
    end

    assign rd_nib  = is_load ? data_in[{counter, 2'b00} +: 4] : result;
    assign reg_wen = !is_stall &&
                     (is_alu_imm || is_alu_reg || is_lui || (is_load && load_data_ready));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            carry <= 1'b0;
        end else begin
            carry <= sum[4];
        end
    end

    // Every register rotates one nibble per clock, rd takes the new nibble on top
    always_ff @(posedge clk) begin
        for (int i = 1; i < NUM_REGS; i++) begin
            if (reg_wen && rd_a == REG_ADDR_BITS'(i)) begin
                regs[i] <= {rd_nib, regs[i][31:4]};
            end else begin
                regs[i] <= {regs[i][3:0], regs[i][31:4]};
            end
        end
    end

    // Holds nibbles 0 to 6 of rs1+imm by counter seven
    always_ff @(posedge clk) begin
        addr_sr <= {sum[3:0], addr_sr[DATA_ADDR_BITS-1:4]};
    end

    assign data_out_nibble     = rs2_nib;
    assign addr_out            = addr_sr;
    assign address_ready       = last && !is_stall && (is_store || load_wait);
    assign instr_complete_core = last && !is_stall && !load_wait;

endmodule

//--- src/nqv_decoder.sv
`timescale 1ns/1ps
// nqv instruction decoder
// Splits an RV32E instruction into class flags, register fields and immediate
module nqv_decoder (
    input  logic [31:0]      instr,
    output logic             is_load,
    output logic             is_store,
    output logic             is_alu_imm,
    output logic             is_alu_reg,
    output logic             is_lui,
    output nqv_pkg::alu_op_t alu_op,
    output logic [3:0]       rs1,
    output logic [3:0]       rs2,
    output logic [3:0]       rd,
    output logic [31:0]      imm
);
    import nqv_pkg::*;

    logic [2:0] funct3;
    logic       funct3_ok;
    logic       funct7_ok;

    assign funct3    = instr[14:12];
    assign funct3_ok = funct3 == 3'b000 || funct3 == 3'b100 || funct3[2:1] == 2'b11;
    assign funct7_ok = !instr[31] && instr[29:25] == 5'd0;  // Only bit 30 may be set

    assign rs1 = instr[18:15];
    assign rs2 = instr[23:20];
    assign rd  = instr[10:7];

    always_comb begin
        is_load    = 1'b0;
        is_store   = 1'b0;
        is_alu_imm = 1'b0;
        is_alu_reg = 1'b0;
        is_lui     = 1'b0;
        alu_op     = ALU_ADD;  // Loads and stores add rs1 and imm
        imm        = {{20{instr[31]}}, instr[31:20]};
        case (instr[6:0])
            7'b0000011: begin
                is_load = funct3 == 3'b010;
            end
            7'b0100011: begin
                is_store = funct3 == 3'b010;
                imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            7'b0010011: begin
                is_alu_imm = funct3_ok;
                alu_op     = alu_op_t'({1'b0, funct3});
            end
            7'b0110011: begin
                is_alu_reg = funct3_ok && funct7_ok;
                alu_op     = alu_op_t'({instr[30] && funct3 == 3'b000, funct3});
            end
            7'b0110111: begin
                is_lui = 1'b1;
                alu_op = ALU_PASS_IMM;
                imm    = {instr[31:12], 12'h000};
            end
            default: begin
                // Anything else runs as an empty round
            end
        endcase
    end

endmodule

//--- src/nqv_fetch.sv
`timescale 1ns/1ps
// nqv prefetch buffer
// Collects halfwords into a four-entry ring and presents the current instruction
module nqv_fetch (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic [15:0]                          instr_data_in,
    input  logic                                 instr_ready,
    input  logic                                 instr_taken,
    output logic [nqv_pkg::INSTR_ADDR_BITS-1:0] instr_addr,
    output logic                                 instr_fetch_restart,
    output logic                                 instr_fetch_stall,
    output logic [31:0]                          instr,
    output logic                                 instr_avail
);
    import nqv_pkg::*;

    logic [15:0]                instr_buf [0:3];
    logic [INSTR_ADDR_BITS-1:0] base_addr;  // Address of the halfword at rd_ofs
    logic [2:0]                 rd_ofs;
    logic [2:0]                 wr_ofs;
    logic [2:0]                 fill;
    logic [1:0]                 rd_hi;
    logic                       started;
    logic                       accept;

    assign fill  = wr_ofs - rd_ofs;
    assign rd_hi = rd_ofs[1:0] + 2'd1;

    assign instr_fetch_restart = !started;
    assign instr_fetch_stall   = fill[2];  // All four entries unread
    assign accept              = instr_ready && started && !fill[2];
    assign instr_addr          = base_addr + INSTR_ADDR_BITS'(fill);

    assign instr_avail = fill >= 3'd2;
    assign instr       = {instr_buf[rd_hi], instr_buf[rd_ofs[1:0]]};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            started   <= 1'b0;
            base_addr <= '0;
            rd_ofs    <= 3'd0;
            wr_ofs    <= 3'd0;
        end else begin
            started <= 1'b1;
            if (accept) begin
                wr_ofs <= wr_ofs + 3'd1;
            end
            if (instr_taken) begin
                rd_ofs    <= rd_ofs + 3'd2;
                base_addr <= base_addr + INSTR_ADDR_BITS'(2);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr_buf[wr_ofs[1:0]] <= instr_data_in;
        end
    end

endmodule

//--- src/nqv_pkg.sv
// nqv shared definitions
// ALU operation codes, bus access sizes and common widths
package nqv_pkg;

    // Instruction bit 30 sits above funct3
    typedef enum logic [3:0] {
        ALU_ADD      = 4'b0000,
        ALU_SUB      = 4'b1000,
        ALU_XOR      = 4'b0100,
        ALU_OR       = 4'b0110,
        ALU_AND      = 4'b0111,
        ALU_PASS_IMM = 4'b1111
    } alu_op_t;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10,
        MEM_NONE = 2'b11
    } mem_size_t;

    localparam int INSTR_ADDR_BITS = 23;  // Halfword address
    localparam int DATA_ADDR_BITS  = 28;  // Byte address
    localparam int NIBBLES         = 8;   // One nibble per clock

endpackage
